/* common/spi_xip_defines.svh */
`ifndef SPI_XIP_DEFINES_SVH
`define SPI_XIP_DEFINES_SVH

// Number of slave select lines
`define SPI_SS_NUM 8

// Width of the serial clock divider
`define SPI_DIV_W 16

// Memory-mapped flash window
`define FLASH_BASE 32'h3000_0000
`define FLASH_END  32'h3FFF_FFFF

// SPI master register window
`define SPI_REG_BASE 32'h1000_1000
`define SPI_REG_END  32'h1000_1FFF

// Serial flash read command
`define FLASH_READ_CMD 8'h03

// Divider programmed for XIP reads, sclk at clock/4
`define XIP_DIVIDER 32'd1

`endif

/* common/spi_xip_pkg.sv */
`default_nettype none

package spi_xip_pkg;

  // Data word of the APB side and of the internal register bus
  typedef logic [31:0] bus_data_t;

  // Register word offsets
  // RX and TX share an offset, reads see RX and writes go to TX
  typedef enum logic [4:0] {
    REG_RXTX0   = 5'h00,
    REG_RXTX1   = 5'h04,
    REG_CTRL    = 5'h10,
    REG_DIVIDER = 5'h14,
    REG_SS      = 5'h18
  } reg_offset_e;

  // XIP read sequencer states
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    SEND_CMD    = 3'd1,
    SET_DIVIDER = 3'd2,
    SET_SS      = 3'd3,
    GO_BUSY     = 3'd4,
    POLL_BUSY   = 3'd5,
    READ_DATA   = 3'd6,
    RESPOND     = 3'd7
  } xip_state_e;

  // CTRL register layout
  // char_len of 0 selects a 64-bit character
  typedef struct packed {
    logic [21:0] rsvd_hi;
    logic        ie;
    logic        go_bsy;
    logic        rsvd_lo;
    logic [6:0]  char_len;
  } ctrl_t;

endpackage

`default_nettype wire

/* common/spi_reg_if.sv */
`default_nettype none

// Internal register bus between the APB bridge and the SPI register file
// stb is held until ack, ack is a single-cycle pulse
interface spi_reg_if;

  // Word offset into the register file
  logic [4:0]             adr;
  spi_xip_pkg::bus_data_t wdata;
  // Byte lane enables
  logic [3:0]             sel;
  logic                   we;
  logic                   stb;

  // Read data, valid with ack
  spi_xip_pkg::bus_data_t rdata;
  logic                   ack;

  modport requester (
    output adr, wdata, sel, we, stb,
    input  rdata, ack
  );

  modport responder (
    input  adr, wdata, sel, we, stb,
    output rdata, ack
  );

endinterface

`default_nettype wire

/* hdl/spi_apb_bridge.sv */
`default_nettype none

`include "spi_xip_defines.svh"

module spi_apb_bridge (
  input  wire logic                    clock,
  input  wire logic                    reset,
  input  wire logic [31:0]             paddr_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire spi_xip_pkg::bus_data_t  pwdata_i,
  input  wire logic [3:0]              pstrb_i,
  output logic                         pready_o,
  output spi_xip_pkg::bus_data_t       prdata_o,
  output logic                         pslverr_o,
  spi_reg_if.requester                 reg_bus
);

  spi_xip_pkg::xip_state_e state_q;
  spi_xip_pkg::xip_state_e next_step;
  logic                    stb_q;
  logic                    pass_q;
  logic                    err_q;
  spi_xip_pkg::bus_data_t  flash_data_q;
  logic                    in_flash;
  logic                    in_regs;
  logic                    new_access;
  spi_xip_pkg::ctrl_t      go_ctrl;
  spi_xip_pkg::ctrl_t      poll_ctrl;

  // Window decode
  assign in_flash = (paddr_i >= `FLASH_BASE) && (paddr_i <= `FLASH_END);
  assign in_regs  = (paddr_i >= `SPI_REG_BASE) && (paddr_i <= `SPI_REG_END);

  // Access phase seen, error cycle excluded so it fires only once
  assign new_access = psel_i && penable_i && !err_q;

  // Polled CTRL word
  assign poll_ctrl = spi_xip_pkg::ctrl_t'(reg_bus.rdata);

  // Request for the current step
  // IDLE passes the APB fields through, paddr is stable until pready
  always_comb begin
    go_ctrl          = '0;
    go_ctrl.go_bsy   = 1'b1;
    go_ctrl.char_len = 7'd0;  // 64-bit character

    reg_bus.adr   = paddr_i[4:0];
    reg_bus.wdata = pwdata_i;
    reg_bus.sel   = pstrb_i;
    reg_bus.we    = pwrite_i;
    next_step     = spi_xip_pkg::IDLE;
    if (state_q != spi_xip_pkg::IDLE) begin
      reg_bus.sel = 4'hF;
      reg_bus.we  = 1'b1;
    end
    case (state_q)
      spi_xip_pkg::SEND_CMD: begin
        // Command byte then 24-bit flash address
        reg_bus.adr   = spi_xip_pkg::REG_RXTX1;
        reg_bus.wdata = {`FLASH_READ_CMD, paddr_i[23:0]};
        next_step     = spi_xip_pkg::SET_DIVIDER;
      end
      spi_xip_pkg::SET_DIVIDER: begin
        reg_bus.adr   = spi_xip_pkg::REG_DIVIDER;
        reg_bus.wdata = `XIP_DIVIDER;
        next_step     = spi_xip_pkg::SET_SS;
      end
      spi_xip_pkg::SET_SS: begin
        // Flash sits on select 0
        reg_bus.adr   = spi_xip_pkg::REG_SS;
        reg_bus.wdata = 32'h0000_0001;
        next_step     = spi_xip_pkg::GO_BUSY;
      end
      spi_xip_pkg::GO_BUSY: begin
        reg_bus.adr   = spi_xip_pkg::REG_CTRL;
        reg_bus.wdata = go_ctrl;
        next_step     = spi_xip_pkg::POLL_BUSY;
      end
      spi_xip_pkg::POLL_BUSY: begin
        reg_bus.adr = spi_xip_pkg::REG_CTRL;
        reg_bus.we  = 1'b0;
        next_step   = spi_xip_pkg::READ_DATA;
      end
      spi_xip_pkg::READ_DATA: begin
        reg_bus.adr = spi_xip_pkg::REG_RXTX0;
        reg_bus.we  = 1'b0;
        next_step   = spi_xip_pkg::RESPOND;
      end
      default: begin
        next_step = spi_xip_pkg::IDLE;
      end
    endcase
  end

  // Sequencer and pass-through control
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= spi_xip_pkg::IDLE;
      stb_q   <= 1'b0;
      pass_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      // Error response lasts one cycle
      err_q <= 1'b0;
      case (state_q)
        spi_xip_pkg::IDLE: begin
          if (pass_q) begin
            // Register access in flight, ends with ack
            if (reg_bus.ack) begin
              stb_q  <= 1'b0;
              pass_q <= 1'b0;
            end
          end else if (new_access) begin
            if (in_regs) begin
              stb_q  <= 1'b1;
              pass_q <= 1'b1;
            end else if (in_flash && !pwrite_i) begin
              state_q <= spi_xip_pkg::SEND_CMD;
            end else begin
              // Unmapped or flash write
              err_q <= 1'b1;
            end
          end
        end
        spi_xip_pkg::RESPOND: begin
          state_q <= spi_xip_pkg::IDLE;
        end
        default: begin
          // One bus cycle per step, stb low for a cycle in between
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (reg_bus.ack) begin
            stb_q <= 1'b0;
            // Keep polling while the transfer runs
            if (state_q != spi_xip_pkg::POLL_BUSY || !poll_ctrl.go_bsy) begin
              state_q <= next_step;
            end
          end
        end
      endcase
    end
  end

  // RX0 word returned by the XIP read
  always_ff @(posedge clock) begin
    if (state_q == spi_xip_pkg::READ_DATA && stb_q && reg_bus.ack) begin
      flash_data_q <= reg_bus.rdata;
    end
  end

  assign reg_bus.stb = stb_q;

  // APB response
  assign pready_o  = (pass_q && reg_bus.ack) || err_q || (state_q == spi_xip_pkg::RESPOND);
  assign pslverr_o = err_q;
  assign prdata_o  = (state_q == spi_xip_pkg::RESPOND) ? flash_data_q : reg_bus.rdata;

endmodule

`default_nettype wire

/* spi_master/spi_regs.sv */
`default_nettype none

`include "spi_xip_defines.svh"

module spi_regs (
  input  wire logic                   clock,
  input  wire logic                   reset,
  spi_reg_if.responder                reg_bus,
  output logic                        start_o,
  output logic [63:0]                 tx_data_o,
  output logic [6:0]                  char_len_o,
  output logic [`SPI_DIV_W-1:0]       divider_o,
  output logic [`SPI_SS_NUM-1:0]      ss_o,
  input  wire logic                   busy_i,
  input  wire logic                   done_i,
  input  wire logic [63:0]            rx_data_i,
  output logic                        irq_o
);

  spi_xip_pkg::bus_data_t  tx0_q;
  spi_xip_pkg::bus_data_t  tx1_q;
  logic [63:0]             rx_q;
  logic [6:0]              char_len_q;
  logic                    ie_q;
  logic [`SPI_DIV_W-1:0]   divider_q;
  logic [`SPI_SS_NUM-1:0]  ss_q;
  logic                    ack_q;
  logic                    start_q;
  logic                    irq_q;
  spi_xip_pkg::bus_data_t  rdata_q;
  logic                    access;
  logic                    wr_en;
  logic                    go_write;
  logic                    busy_any;
  spi_xip_pkg::ctrl_t      ctrl_view;
  spi_xip_pkg::ctrl_t      ctrl_new;
  spi_xip_pkg::bus_data_t  cur_word;
  spi_xip_pkg::bus_data_t  wr_word;
  spi_xip_pkg::bus_data_t  rd_word;

  // Byte-lane merge of a write into the current word
  function automatic spi_xip_pkg::bus_data_t merge_lanes(
    input spi_xip_pkg::bus_data_t old_word,
    input spi_xip_pkg::bus_data_t new_word,
    input logic [3:0]             lanes
  );
    spi_xip_pkg::bus_data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Busy from go write on, covers the cycle before the engine reports
  assign busy_any = busy_i || start_q;

  // First strobe cycle only
  assign access = reg_bus.stb && !ack_q;
  assign wr_en  = access && reg_bus.we && !busy_any;

  always_comb begin
    ctrl_view          = '0;
    ctrl_view.ie       = ie_q;
    ctrl_view.go_bsy   = busy_any;
    ctrl_view.char_len = char_len_q;

    // Write-side view of the addressed register
    case (reg_bus.adr)
      spi_xip_pkg::REG_RXTX0:   cur_word = tx0_q;
      spi_xip_pkg::REG_RXTX1:   cur_word = tx1_q;
      spi_xip_pkg::REG_CTRL:    cur_word = ctrl_view;
      spi_xip_pkg::REG_DIVIDER: cur_word = spi_xip_pkg::bus_data_t'(divider_q);
      spi_xip_pkg::REG_SS:      cur_word = spi_xip_pkg::bus_data_t'(ss_q);
      default:                  cur_word = '0;
    endcase

    // Reads of the data offsets return received bits
    case (reg_bus.adr)
      spi_xip_pkg::REG_RXTX0: rd_word = rx_q[31:0];
      spi_xip_pkg::REG_RXTX1: rd_word = rx_q[63:32];
      default:                rd_word = cur_word;
    endcase
  end

  assign wr_word  = merge_lanes(cur_word, reg_bus.wdata, reg_bus.sel);
  assign ctrl_new = spi_xip_pkg::ctrl_t'(wr_word);
  assign go_write = wr_en && (reg_bus.adr == spi_xip_pkg::REG_CTRL) && ctrl_new.go_bsy;

  // Control registers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q      <= 1'b0;
      start_q    <= 1'b0;
      char_len_q <= '0;
      ie_q       <= 1'b0;
      divider_q  <= '0;
      ss_q       <= '0;
      irq_q      <= 1'b0;
    end else begin
      ack_q   <= access;
      start_q <= go_write;
      if (wr_en) begin
        case (reg_bus.adr)
          spi_xip_pkg::REG_CTRL: begin
            char_len_q <= ctrl_new.char_len;
            ie_q       <= ctrl_new.ie;
          end
          spi_xip_pkg::REG_DIVIDER: divider_q <= wr_word[`SPI_DIV_W-1:0];
          spi_xip_pkg::REG_SS:      ss_q      <= wr_word[`SPI_SS_NUM-1:0];
          default: ;
        endcase
      end
      // Flag set at end of transfer, cleared by the next go
      if (go_write) begin
        irq_q <= 1'b0;
      end else if (done_i && ie_q) begin
        irq_q <= 1'b1;
      end
    end
  end

  // Data registers and read capture
  always_ff @(posedge clock) begin
    if (wr_en && reg_bus.adr == spi_xip_pkg::REG_RXTX0) begin
      tx0_q <= wr_word;
    end
    if (wr_en && reg_bus.adr == spi_xip_pkg::REG_RXTX1) begin
      tx1_q <= wr_word;
    end
    if (done_i) begin
      rx_q <= rx_data_i;
    end
    if (access) begin
      rdata_q <= rd_word;
    end
  end

  assign reg_bus.ack   = ack_q;
  assign reg_bus.rdata = rdata_q;

  assign start_o    = start_q;
  assign tx_data_o  = {tx1_q, tx0_q};
  assign char_len_o = char_len_q;
  assign divider_o  = divider_q;
  assign ss_o       = ss_q;
  assign irq_o      = irq_q;

endmodule

`default_nettype wire

/* spi_master/spi_shift.sv */
`default_nettype none

`include "spi_xip_defines.svh"

module spi_shift (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   start_i,
  input  wire logic [63:0]            tx_data_i,
  input  wire logic [6:0]             char_len_i,
  input  wire logic [`SPI_DIV_W-1:0]  divider_i,
  input  wire logic [`SPI_SS_NUM-1:0] ss_i,
  output logic                        busy_o,
  output logic                        done_o,
  output logic [63:0]                 rx_data_o,
  output logic                        sclk_o,
  output logic                        mosi_o,
  output logic [`SPI_SS_NUM-1:0]      ss_n_o,
  input  wire logic                   miso_i
);

  logic                  busy_q;
  logic                  done_q;
  logic                  sclk_q;
  logic [`SPI_DIV_W-1:0] div_cnt_q;
  logic [6:0]            bits_left_q;
  logic [63:0]           tx_shift_q;
  logic [63:0]           rx_shift_q;
  logic [6:0]            char_bits;
  logic [6:0]            align;
  logic                  load;
  logic                  tick;

  // Length 0 encodes 64 bits
  assign char_bits = (char_len_i == 7'd0) ? 7'd64 : char_len_i;
  // Moves bit char_len-1 up to bit 63
  assign align     = 7'd64 - char_bits;

  assign load = start_i && !busy_q;
  // sclk edge every divider+1 clocks
  assign tick = busy_q && (div_cnt_q == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      sclk_q      <= 1'b0;
      div_cnt_q   <= '0;
      bits_left_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        busy_q      <= 1'b1;
        sclk_q      <= 1'b0;
        div_cnt_q   <= divider_i;
        bits_left_q <= char_bits;
      end else if (busy_q) begin
        if (tick) begin
          div_cnt_q <= divider_i;
          sclk_q    <= !sclk_q;
          // Falling edge closes a bit
          if (sclk_q) begin
            bits_left_q <= bits_left_q - 7'd1;
            if (bits_left_q == 7'd1) begin
              busy_q <= 1'b0;
              done_q <= 1'b1;
            end
          end
        end else begin
          div_cnt_q <= div_cnt_q - 1'b1;
        end
      end
    end
  end

  // Shift registers
  // tx moves on falling edges, miso is taken on rising edges
  always_ff @(posedge clock) begin
    if (load) begin
      tx_shift_q <= tx_data_i << align;
      rx_shift_q <= '0;
    end else if (tick) begin
      if (sclk_q) begin
        tx_shift_q <= {tx_shift_q[62:0], 1'b0};
      end else begin
        rx_shift_q <= {rx_shift_q[62:0], miso_i};
      end
    end
  end

  assign busy_o    = busy_q;
  assign done_o    = done_q;
  assign rx_data_o = rx_shift_q;
  assign sclk_o    = sclk_q;
  // MSB first, held low when idle
  assign mosi_o    = busy_q && tx_shift_q[63];
  // Active-low selects only during a transfer
  assign ss_n_o    = ~(ss_i & {`SPI_SS_NUM{busy_q}});

endmodule

`default_nettype wire

/* hdl/spi_xip_top.sv */
`default_nettype none

`include "spi_xip_defines.svh"

module spi_xip_top (
  input  wire logic                    clock,
  input  wire logic                    reset,
  // APB
  input  wire logic [31:0]             paddr_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic [2:0]              pprot_i,
  input  wire logic                    pwrite_i,
  input  wire spi_xip_pkg::bus_data_t  pwdata_i,
  input  wire logic [3:0]              pstrb_i,
  output logic                         pready_o,
  output spi_xip_pkg::bus_data_t       prdata_o,
  output logic                         pslverr_o,
  // SPI pads
  output logic                         sclk_o,
  output logic [`SPI_SS_NUM-1:0]       ss_n_o,
  output logic                         mosi_o,
  input  wire logic                    miso_i,
  output logic                         irq_o
);

  // Register file to shift engine
  logic                   start;
  logic [63:0]            tx_data;
  logic [6:0]             char_len;
  logic [`SPI_DIV_W-1:0]  divider;
  logic [`SPI_SS_NUM-1:0] ss;
  logic                   busy;
  logic                   done;
  logic [63:0]            rx_data;

  // Bridge to register file
  spi_reg_if i_reg_bus ();

  // pprot_i has no effect on access rights
  spi_apb_bridge i_spi_apb_bridge (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .reg_bus   (i_reg_bus.requester)
  );

  spi_regs i_spi_regs (
    .clock      (clock),
    .reset      (reset),
    .reg_bus    (i_reg_bus.responder),
    .start_o    (start),
    .tx_data_o  (tx_data),
    .char_len_o (char_len),
    .divider_o  (divider),
    .ss_o       (ss),
    .busy_i     (busy),
    .done_i     (done),
    .rx_data_i  (rx_data),
    .irq_o      (irq_o)
  );

  spi_shift i_spi_shift (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .tx_data_i  (tx_data),
    .char_len_i (char_len),
    .divider_i  (divider),
    .ss_i       (ss),
    .busy_o     (busy),
    .done_o     (done),
    .rx_data_o  (rx_data),
    .sclk_o     (sclk_o),
    .mosi_o     (mosi_o),
    .ss_n_o     (ss_n_o),
    .miso_i     (miso_i)
  );

endmodule

`default_nettype wire

/* dv/spi_flash_model.sv */
`default_nettype none

`include "spi_xip_defines.svh"

// Serial flash, SPI mode 0, answers only the read command
// Data byte at address a is a[7:0] ^ A5h, bytes sent MSB first
module spi_flash_model (
  input  wire logic sclk_i,
  input  wire logic ss_n_i,
  input  wire logic mosi_i,
  output logic      miso_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Command byte and 24-bit address as received
  logic [31:0] cmd_addr;
  logic [31:0] read_word;
  int          bit_cnt;

  // Content of one flash byte
  function automatic logic [7:0] pattern_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'hA5;
  endfunction

  initial begin
    miso_o    = 1'b0;
    bit_cnt   = 0;
    cmd_addr  = '0;
    read_word = '0;
  end

  // New frame on select falling
  always @(negedge ss_n_i) begin
    bit_cnt = 0;
    miso_o <= 1'b0;
  end

  always @(posedge ss_n_i) begin
    miso_o <= 1'b0;
  end

  // mosi taken on rising sclk, only the header is kept
  always @(posedge sclk_i) begin
    if (!ss_n_i) begin
      if (bit_cnt < 32) begin
        cmd_addr = {cmd_addr[30:0], mosi_i};
      end
      bit_cnt = bit_cnt + 1;
    end
  end

  // Data bits change on falling sclk after the header
  always @(negedge sclk_i) begin
    if (!ss_n_i && bit_cnt >= 32 && bit_cnt < 64 && cmd_addr[31:24] == `FLASH_READ_CMD) begin
      if (bit_cnt == 32) begin
        read_word = {pattern_byte(cmd_addr[23:0]),
                     pattern_byte(cmd_addr[23:0] + 24'd1),
                     pattern_byte(cmd_addr[23:0] + 24'd2),
                     pattern_byte(cmd_addr[23:0] + 24'd3)};
      end
      miso_o <= read_word[63 - bit_cnt];
    end
  end

endmodule

`default_nettype wire

/* dv/tb_spi_xip.sv */
`default_nettype none

`include "spi_xip_defines.svh"

module tb_spi_xip;

  timeunit 1ns;
  timeprecision 1ps;

  // Limits in clock cycles
  localparam int APB_TIMEOUT     = 1000;
  localparam int MAX_POLLS       = 1000;
  localparam int CYCLES_PER_TEST = 2000;

  // One line of the test file
  typedef struct packed {
    logic [7:0]             op;
    logic [31:0]            addr;
    spi_xip_pkg::bus_data_t wdata;
    logic [3:0]             strb;
    spi_xip_pkg::bus_data_t exp_data;
    logic                   exp_err;
  } test_line_t;

  logic                   clock;
  logic                   reset;
  logic [31:0]            paddr;
  logic                   psel;
  logic                   penable;
  logic [2:0]             pprot;
  logic                   pwrite;
  spi_xip_pkg::bus_data_t pwdata;
  logic [3:0]             pstrb;
  logic                   pready;
  spi_xip_pkg::bus_data_t prdata;
  logic                   pslverr;
  logic                   sclk;
  logic [`SPI_SS_NUM-1:0] ss_n;
  logic                   mosi;
  logic                   miso;
  logic                   irq;

  // Select lines seen in the pready cycle of the last APB transfer
  logic [`SPI_SS_NUM-1:0] ss_at_ready;
  test_line_t             tests[$];
  bit                     tests_loaded;

  spi_xip_top i_spi_xip_top (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pprot_i   (pprot),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .sclk_o    (sclk),
    .ss_n_o    (ss_n),
    .mosi_o    (mosi),
    .miso_i    (miso),
    .irq_o     (irq)
  );

  // Flash on select 0
  spi_flash_model i_spi_flash_model (
    .sclk_i (sclk),
    .ss_n_i (ss_n[0]),
    .mosi_i (mosi),
    .miso_o (miso)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input spi_xip_pkg::bus_data_t exp,
                            input spi_xip_pkg::bus_data_t got);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_err(input bit exp, input bit got);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch pslverr_o exp=%h got=%h", exp, got));
    end
  endtask

  task automatic check_irq(input bit exp, input bit got);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch irq_o exp=%h got=%h", exp, got));
    end
  endtask

  task automatic check_ss(input logic [`SPI_SS_NUM-1:0] exp,
                          input logic [`SPI_SS_NUM-1:0] got);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch ss_n_o exp=%h got=%h", exp, got));
    end
  endtask

  // One APB transfer, setup then access phase until pready
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input spi_xip_pkg::bus_data_t wdata, input logic [3:0] strb,
                              output spi_xip_pkg::bus_data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clock);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    pstrb   = write ? strb : 4'h0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    do begin
      @(negedge clock);
      waited++;
      if (waited > APB_TIMEOUT) begin
        abort_run($sformatf("pready stayed low for %0d cycles at address %h", waited, addr));
      end
    end while (!pready);
    rdata       = prdata;
    err         = pslverr;
    ss_at_ready = ss_n;
    // Transfer completes on the next rising edge
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input spi_xip_pkg::bus_data_t wdata,
                           input logic [3:0] strb, output logic err);
    spi_xip_pkg::bus_data_t unused;
    apb_transfer(1'b1, addr, wdata, strb, unused, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output spi_xip_pkg::bus_data_t rdata,
                          output logic err);
    apb_transfer(1'b0, addr, '0, 4'h0, rdata, err);
  endtask

  // Reads status until the masked bits clear
  // Selects checked on the first busy read and after the end
  task automatic poll_until_clear(input logic [31:0] addr, input spi_xip_pkg::bus_data_t mask,
                                  input logic [`SPI_SS_NUM-1:0] busy_ss);
    spi_xip_pkg::bus_data_t rdata;
    logic                   err;
    int                     polls;
    polls = 0;
    apb_read(addr, rdata, err);
    check_err(1'b0, err);
    if ((rdata & mask) == '0) begin
      abort_run("Transfer was not busy at the first status poll");
    end
    check_ss(busy_ss, ss_at_ready);
    while ((rdata & mask) != '0) begin
      polls++;
      if (polls > MAX_POLLS) begin
        abort_run($sformatf("Busy bit still set after %0d polls", polls));
      end
      apb_read(addr, rdata, err);
      check_err(1'b0, err);
    end
    check_ss({`SPI_SS_NUM{1'b1}}, ss_at_ready);
  endtask

  task automatic load_tests();
    int         fd;
    int         n;
    string      line;
    test_line_t t;
    logic [7:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] strb;
    logic [31:0] exp_data;
    logic       exp_err;
    fd = $fopen("dv/spi_xip_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open test file dv/spi_xip_tests.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb, exp_data, exp_err);
      if (n != 6) begin
        abort_run($sformatf("Malformed test line: %s", line));
      end
      t.op       = op;
      t.addr     = addr;
      t.wdata    = wdata;
      t.strb     = strb;
      t.exp_data = exp_data;
      t.exp_err  = exp_err;
      tests.push_back(t);
    end
    $fclose(fd);
    if (tests.size() == 0) begin
      abort_run("Test file holds no test lines");
    end
    tests_loaded = 1'b1;
  endtask

  task automatic run_test(input test_line_t t);
    spi_xip_pkg::bus_data_t rdata;
    logic                   err;
    case (t.op)
      "W": begin
        apb_write(t.addr, t.wdata, t.strb, err);
        check_err(t.exp_err, err);
      end
      "R", "X": begin
        apb_read(t.addr, rdata, err);
        check_err(t.exp_err, err);
        // Read data undefined on an error response
        if (!t.exp_err) begin
          check_data("prdata_o", t.exp_data, rdata);
        end
      end
      "P": begin
        poll_until_clear(t.addr, t.wdata, t.exp_data[`SPI_SS_NUM-1:0]);
      end
      "S": begin
        @(negedge clock);
        check_ss(t.exp_data[`SPI_SS_NUM-1:0], ss_n);
      end
      "I": begin
        @(negedge clock);
        check_irq(t.exp_data[0], irq);
      end
      default: begin
        abort_run($sformatf("Unknown test operation %s", t.op));
      end
    endcase
  endtask

  // Run limit scales with the number of test lines
  initial begin
    wait (tests_loaded);
    repeat (CYCLES_PER_TEST * tests.size()) @(posedge clock);
    $display("Watchdog timeout after %0d cycles", CYCLES_PER_TEST * tests.size());
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    reset        = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pprot        = 3'b000;
    pwrite       = 1'b0;
    pwdata       = '0;
    pstrb        = 4'h0;
    ss_at_ready  = '1;
    tests_loaded = 1'b0;
    load_tests();
    // Reset over three clock cycles, released on a falling edge
    repeat (3) @(negedge clock);
    reset = 1'b0;
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/spi_xip_tests.txt */
# op addr wdata strb exp_data exp_err, all hex; P polls addr until (data & wdata) is 0
# S checks ss_n_o, I checks irq_o bit 0, P expects ss_n_o while busy in exp_data
S 00000000 00000000 0 000000FF 0
I 00000000 00000000 0 00000000 0
R 10001010 00000000 0 00000000 0
R 10001014 00000000 0 00000000 0
R 10001018 00000000 0 00000000 0
# Register readback with byte lanes
W 10001014 FFFFABCD F 00000000 0
R 10001014 00000000 0 0000ABCD 0
W 10001014 00001200 2 00000000 0
R 10001014 00000000 0 000012CD 0
W 10001018 000000A5 F 00000000 0
R 10001018 00000000 0 000000A5 0
W 10001018 0000FF3C 1 00000000 0
R 10001018 00000000 0 0000003C 0
W 10001010 FFFFFEFF F 00000000 0
R 10001010 00000000 0 0000027F 0
W 10001010 00000000 F 00000000 0
R 10001010 00000000 0 00000000 0
# Manual flash read, TX1 built from byte lanes to 03AB1234
W 10001000 00000000 F 00000000 0
W 10001004 03000000 F 00000000 0
W 10001004 FFFF1234 3 00000000 0
W 10001004 00ABFFFF 4 00000000 0
W 10001014 00000001 F 00000000 0
W 10001018 00000001 F 00000000 0
S 00000000 00000000 0 000000FF 0
W 10001010 00000100 F 00000000 0
P 10001010 00000100 0 000000FE 0
R 10001000 00000000 0 91909392 0
I 00000000 00000000 0 00000000 0
S 00000000 00000000 0 000000FF 0
# Interrupt with ie set, then cleared by go
W 10001010 00000308 F 00000000 0
P 10001010 00000100 0 000000FE 0
I 00000000 00000000 0 00000001 0
R 10001010 00000000 0 00000208 0
W 10001010 00000308 F 00000000 0
I 00000000 00000000 0 00000000 0
P 10001010 00000100 0 000000FE 0
I 00000000 00000000 0 00000001 0
W 10001010 00000108 F 00000000 0
I 00000000 00000000 0 00000000 0
P 10001010 00000100 0 000000FE 0
I 00000000 00000000 0 00000000 0
# XIP reads
X 30000100 00000000 0 A5A4A7A6 0
X 3FABCDF0 00000000 0 55545756 0
X 300000FE 00000000 0 5B5AA5A4 0
X 30001234 00000000 0 91909392 0
S 00000000 00000000 0 000000FF 0
# Error responses
R 20000000 00000000 0 00000000 1
R 10002000 00000000 0 00000000 1
W 30000000 12345678 F 00000000 1
R 10001018 00000000 0 00000001 0

/* spi_xip.f */
+incdir+common
common/spi_xip_pkg.sv
common/spi_reg_if.sv
hdl/spi_apb_bridge.sv
spi_master/spi_regs.sv
spi_master/spi_shift.sv
hdl/spi_xip_top.sv
dv/spi_flash_model.sv
dv/tb_spi_xip.sv
